/* verilog/friscv_pmp_defines.svh */
// Global sizing macros for the PMP checker
// Register width, physical address width and region count

`ifndef FRISCV_PMP_DEFINES_SVH
`define FRISCV_PMP_DEFINES_SVH

//////////////////////////////
// Architecture widths
//////////////////////////////

// Register width of 32 bits for RV32
`define XLEN 32

// Physical address width
// Sv32 gives 34 bits of physical address on RV32
`define RLEN 34

//////////////////////////////
// PMP sizing
//////////////////////////////

// Number of implemented PMP entries
// Lower index wins when several entries hit
`define PMP_NB_REGION 4

`endif

/* verilog/friscv_pmp_pkg.sv */
// Types shared by the PMP checker
// Address-match mode and access opcode enums

`default_nettype none

package friscv_pmp_pkg;

    //////////////////////////////
    // Cfg byte layout
    //////////////////////////////

    // bit 0    R, read permission
    // bit 1    W, write permission
    // bit 2    X, execute permission
    // bits 4:3 A, address-match mode
    // bits 6:5 reserved, read as zero
    // bit 7    L, entry locked and enforced in machine mode

    // Address-match mode held in the A field
    typedef enum logic [1:0] {
        OFF   = 2'd0,
        TOR   = 2'd1,
        NA4   = 2'd2,
        NAPOT = 2'd3
    } pmp_mode_e;

    // Access opcode of a request
    // Value matches the cfg bit it checks
    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_EXEC  = 2'd2
    } pmp_access_e;

endpackage

`default_nettype wire

/* verilog/friscv_pmp_csr.sv */
// PMP configuration and address register bank
// Strobed writes with per-entry lock protection

`timescale 1ns/1ps
`default_nettype none

`include "friscv_pmp_defines.svh"

module friscv_pmp_csr (
    input  wire                                aclk,
    input  wire                                reset,
    // Write strobe from the CSR side
    input  wire                                csr_wren,
    input  wire                                csr_wr_is_cfg,
    input  wire  [$clog2(`PMP_NB_REGION)-1:0]  csr_wr_idx,
    input  wire  [`XLEN-1:0]                   csr_wr_data,
    // Flattened register outputs, slice i belongs to region i
    output logic [`PMP_NB_REGION*8-1:0]        pmp_cfg_all,
    output logic [`PMP_NB_REGION*`XLEN-1:0]    pmp_addr_all
);

    //////////////////////////////
    // Local definitions
    //////////////////////////////

    // Lock bit in the cfg byte
    localparam int CFG_L = 7;

    // One cfg byte and one pmpaddr word per entry
    logic [7:0]       cfg_q  [`PMP_NB_REGION];
    logic [`XLEN-1:0] addr_q [`PMP_NB_REGION];

    // Target entry is locked, write must be dropped
    logic             wr_locked;
    // Write accepted this cycle
    logic             wr_accept;

    //////////////////////////////
    // Write qualification
    //////////////////////////////

    // L bit protects both the cfg byte and pmpaddr of the same entry
    assign wr_locked = cfg_q[csr_wr_idx][CFG_L];
    assign wr_accept = csr_wren && !wr_locked;

    //////////////////////////////
    // Register bank
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset) begin
            // All entries cleared, so every region starts OFF
            for (int i = 0; i < `PMP_NB_REGION; i++) begin
                cfg_q[i]  <= 8'h00;
                addr_q[i] <= '0;
            end
        end else if (wr_accept) begin
            if (csr_wr_is_cfg) begin
                // Only the low byte carries the cfg field
                cfg_q[csr_wr_idx] <= csr_wr_data[7:0];
            end else begin
                addr_q[csr_wr_idx] <= csr_wr_data;
            end
        end
    end

    //////////////////////////////
    // Flattened outputs
    //////////////////////////////

    // Entry i lands on slice i of each bus
    for (genvar i = 0; i < `PMP_NB_REGION; i++) begin : gen_flat
        assign pmp_cfg_all[i*8 +: 8]         = cfg_q[i];
        assign pmp_addr_all[i*`XLEN +: `XLEN] = addr_q[i];
    end

endmodule

`default_nettype wire

/* verilog/friscv_pmp_region.sv */
// Single PMP region decoder
// Base and mask computation plus per-mode address hit

`timescale 1ns/1ps
`default_nettype none

`include "friscv_pmp_defines.svh"

module friscv_pmp_region #(
    // Register width, 32 on RV32, 64 on RV64
    parameter int XLEN = `XLEN,
    // Physical address width, 34 on RV32, 56 on RV64
    parameter int RLEN = `RLEN
) (
    // Entry registers
    input  wire  [XLEN-1:0] pmp_addr,
    input  wire  [7:0]      pmp_cfg,
    // Lower bound for TOR, from the previous entry
    input  wire  [RLEN-1:0] prev_base,
    // Physical address under check
    input  wire  [RLEN-1:0] req_addr,
    // Region base, upper bound under TOR
    output logic [RLEN-1:0] pmp_base,
    output logic            hit
);

    import friscv_pmp_pkg::*;

    //////////////////////////////
    // Local definitions
    //////////////////////////////

    // A field position in the cfg byte
    localparam int CFG_A_LO = 3;
    localparam int CFG_A_HI = 4;

    pmp_mode_e       mode;
    // pmpaddr scaled to a byte address, widened by two bits
    logic [XLEN+1:0] addr_ext;
    logic [RLEN-1:0] addr_shift;
    // Address bits compared for NA4 and NAPOT
    logic [RLEN-1:0] pmp_mask;
    // log2 of the NAPOT region size in bytes
    int unsigned     napot_size;

    // Index of the lowest zero bit, XLEN when all bits are set
    function automatic int unsigned lowest_zero(input logic [XLEN-1:0] value);
        int unsigned idx;
        idx = XLEN;
        // Scan downwards so the lowest zero is kept last
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (!value[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    //////////////////////////////
    // Base and mask
    //////////////////////////////

    assign mode       = pmp_mode_e'(pmp_cfg[CFG_A_HI:CFG_A_LO]);
    assign addr_ext   = {pmp_addr, 2'b00};
    assign addr_shift = addr_ext[RLEN-1:0];
    // k trailing ones encode a 2^(k+3) byte region
    assign napot_size = lowest_zero(pmp_addr) + 3;

    always_comb begin
        case (mode)
            NA4: begin
                // Single 4-byte word
                pmp_mask = {RLEN{1'b1}} << 2;
                pmp_base = addr_shift & pmp_mask;
            end
            NAPOT: begin
                // Shift past RLEN gives an empty mask, whole space
                pmp_mask = {RLEN{1'b1}} << napot_size;
                pmp_base = addr_shift & pmp_mask;
            end
            default: begin
                // OFF and TOR keep the plain scaled address
                pmp_mask = '0;
                pmp_base = addr_shift;
            end
        endcase
    end

    //////////////////////////////
    // Address hit
    //////////////////////////////

    always_comb begin
        case (mode)
            OFF:     hit = 1'b0;
            // Half-open range [prev_base, pmp_base)
            TOR:     hit = (req_addr >= prev_base) && (req_addr < pmp_base);
            default: hit = ((req_addr & pmp_mask) == pmp_base);
        endcase
    end

endmodule

`default_nettype wire

/* verilog/friscv_pmp_match.sv */
// PMP priority selection and permission check
// Lowest hitting region decides, verdict registered one cycle later

`timescale 1ns/1ps
`default_nettype none

`include "friscv_pmp_defines.svh"

module friscv_pmp_match (
    input  wire                              aclk,
    input  wire                              reset,
    // Request strobe and fields
    input  wire                              req_valid,
    input  wire friscv_pmp_pkg::pmp_access_e req_access,
    input  wire                              req_machine,
    // One hit flag per region
    input  wire  [`PMP_NB_REGION-1:0]        region_hit,
    // Flattened cfg bytes with 8 bits per region
    input  wire  [`PMP_NB_REGION*8-1:0]      pmp_cfg_all,
    // Verdict one cycle after the request
    output logic                             resp_valid,
    output logic                             resp_allow
);

    import friscv_pmp_pkg::*;

    //////////////////////////////
    // Local definitions
    //////////////////////////////

    // Permission and lock bits in the cfg byte
    localparam int CFG_R = 0;
    localparam int CFG_W = 1;
    localparam int CFG_X = 2;
    localparam int CFG_L = 7;

    localparam int IDX_W = (`PMP_NB_REGION > 1) ? $clog2(`PMP_NB_REGION) : 1;

    // Winning region
    logic             any_hit;
    logic [IDX_W-1:0] sel_idx;
    logic [7:0]       sel_cfg;
    // Permission bit of the selected entry for this access
    logic             perm;
    logic             locked;
    // Combinational verdict before the output register
    logic             verdict;

    //////////////////////////////
    // Priority selection
    //////////////////////////////

    always_comb begin
        any_hit = 1'b0;
        sel_idx = '0;
        // Walk from the top so the lowest index overwrites last
        for (int i = `PMP_NB_REGION - 1; i >= 0; i--) begin
            if (region_hit[i]) begin
                any_hit = 1'b1;
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel_cfg = pmp_cfg_all[sel_idx*8 +: 8];
    assign locked  = sel_cfg[CFG_L];

    //////////////////////////////
    // Permission check
    //////////////////////////////

    // Opcode picks R, W or X
    always_comb begin
        case (req_access)
            ACC_READ:  perm = sel_cfg[CFG_R];
            ACC_WRITE: perm = sel_cfg[CFG_W];
            ACC_EXEC:  perm = sel_cfg[CFG_X];
            default:   perm = 1'b0;
        endcase
    end

    always_comb begin
        if (!any_hit) begin
            // Machine passes and user fails when nothing matches
            verdict = req_machine;
        end else if (req_machine) begin
            // Machine mode only bound by locked entries
            verdict = !(locked && !perm);
        end else begin
            verdict = perm;
        end
    end

    //////////////////////////////
    // Response register
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset) begin
            resp_valid <= 1'b0;
            resp_allow <= 1'b0;
        end else begin
            resp_valid <= req_valid;
            // Allow stays low outside a response cycle
            resp_allow <= req_valid && verdict;
        end
    end

endmodule

`default_nettype wire

/* verilog/friscv_pmp.sv */
// PMP checker top level
// Register bank, region decoders and match stage

`timescale 1ns/1ps
`default_nettype none

`include "friscv_pmp_defines.svh"

module friscv_pmp (
    input  wire                               aclk,
    input  wire                               reset,
    // CSR write port
    input  wire                               csr_wren,
    input  wire                               csr_wr_is_cfg,
    input  wire  [$clog2(`PMP_NB_REGION)-1:0] csr_wr_idx,
    input  wire  [`XLEN-1:0]                  csr_wr_data,
    // Access request
    input  wire                               req_valid,
    input  wire  [`RLEN-1:0]                  req_addr,
    input  wire friscv_pmp_pkg::pmp_access_e  req_access,
    input  wire                               req_machine,
    // Verdict
    output logic                              resp_valid,
    output logic                              resp_allow
);

    //////////////////////////////
    // Internal wires
    //////////////////////////////

    logic [`PMP_NB_REGION*8-1:0]         pmp_cfg_all;
    logic [`PMP_NB_REGION*`XLEN-1:0]     pmp_addr_all;
    logic [`PMP_NB_REGION-1:0]           region_hit;
    // Slice i is the lower bound of region i, slice i+1 its base
    logic [(`PMP_NB_REGION+1)*`RLEN-1:0] base_chain;

    // Region 0 is bounded below by address zero
    assign base_chain[0 +: `RLEN] = '0;

    friscv_pmp_csr u_csr (
        .aclk          (aclk),
        .reset         (reset),
        .csr_wren      (csr_wren),
        .csr_wr_is_cfg (csr_wr_is_cfg),
        .csr_wr_idx    (csr_wr_idx),
        .csr_wr_data   (csr_wr_data),
        .pmp_cfg_all   (pmp_cfg_all),
        .pmp_addr_all  (pmp_addr_all)
    );

    //////////////////////////////
    // Region decoders
    //////////////////////////////

    for (genvar i = 0; i < `PMP_NB_REGION; i++) begin : gen_region
        friscv_pmp_region #(
            .XLEN (`XLEN),
            .RLEN (`RLEN)
        ) u_region (
            .pmp_addr  (pmp_addr_all[i*`XLEN +: `XLEN]),
            .pmp_cfg   (pmp_cfg_all[i*8 +: 8]),
            .prev_base (base_chain[i*`RLEN +: `RLEN]),
            .req_addr  (req_addr),
            .pmp_base  (base_chain[(i+1)*`RLEN +: `RLEN]),
            .hit       (region_hit[i])
        );
    end

    friscv_pmp_match u_match (
        .aclk        (aclk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_access  (req_access),
        .req_machine (req_machine),
        .region_hit  (region_hit),
        .pmp_cfg_all (pmp_cfg_all),
        .resp_valid  (resp_valid),
        .resp_allow  (resp_allow)
    );

endmodule

`default_nettype wire

/* verification/friscv_pmp_asserts.sv */
// Concurrent assertions on the PMP match stage
// Response timing and idle-level rules

`timescale 1ns/1ps
`default_nettype none

module friscv_pmp_asserts (
    input wire aclk,
    input wire reset,
    input wire req_valid,
    input wire resp_valid,
    input wire resp_allow
);

    // Response follows each request by exactly one cycle
    resp_follows_req: assert property (
        @(posedge aclk) disable iff (reset) req_valid |=> resp_valid
    ) else $error("resp_valid missing one cycle after req_valid");

    // Synchronous reset clears the response strobe
    resp_low_in_reset: assert property (
        @(posedge aclk) reset |=> !resp_valid
    ) else $error("resp_valid high after a reset cycle");

    // Allow never leaks outside a response cycle
    allow_only_with_valid: assert property (
        @(posedge aclk) disable iff (reset) !resp_valid |-> !resp_allow
    ) else $error("resp_allow high while resp_valid low");

    // No response without a request one cycle earlier
    resp_needs_req: assert property (
        @(posedge aclk) disable iff (reset) resp_valid |-> $past(req_valid)
    ) else $error("resp_valid without a request in the previous cycle");

endmodule

// Attach to every match stage instance
bind friscv_pmp_match friscv_pmp_asserts i_asserts (
    .aclk       (aclk),
    .reset      (reset),
    .req_valid  (req_valid),
    .resp_valid (resp_valid),
    .resp_allow (resp_allow)
);

`default_nettype wire

/* verification/friscv_pmp_tb.sv */
// Testbench for the PMP checker
// Shadow model, response checks and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "friscv_pmp_defines.svh"

module friscv_pmp_tb;

    import friscv_pmp_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_DIRECTED   = 44;
    localparam int N_RANDOM     = 200;

    logic                              aclk;
    logic                              reset;
    logic                              csr_wren;
    logic                              csr_wr_is_cfg;
    logic [$clog2(`PMP_NB_REGION)-1:0] csr_wr_idx;
    logic [`XLEN-1:0]                  csr_wr_data;
    logic                              req_valid;
    logic [`RLEN-1:0]                  req_addr;
    pmp_access_e                       req_access;
    logic                              req_machine;
    logic                              resp_valid;
    logic                              resp_allow;

    // Shadow copies of the register bank
    logic [7:0]       shadow_cfg  [`PMP_NB_REGION];
    logic [`XLEN-1:0] shadow_addr [`PMP_NB_REGION];
    // Expected verdicts and test names, in request order
    logic             exp_q  [$];
    string            name_q [$];
    logic             exp_allow;
    string            exp_name;
    int               seed = 39713;
    logic [31:0]      r;
    logic [31:0]      a2;
    logic [`RLEN-1:0] base;
    int               size;
    // Trailing ones in pmpaddr for each NAPOT size under test
    int               napot_k [3] = '{0, 4, 9};

    friscv_pmp i_dut (.*);

    always #4 aclk = ~aclk;

    // Reference verdict from the hit and priority rules
    function automatic logic model_allow(input logic [`RLEN-1:0] addr,
                                         input pmp_access_e acc, input logic machine);
        logic [`RLEN:0] lo;
        logic [`RLEN:0] hi;
        logic [`RLEN:0] a;
        logic           perm;
        int             k;
        a = {1'b0, addr};
        for (int i = 0; i < `PMP_NB_REGION; i++) begin
            lo = {1'b0, shadow_addr[i], 2'b00};
            hi = lo;
            case (shadow_cfg[i][4:3])
                2'd1: begin
                    // TOR takes the previous pmpaddr as lower bound
                    lo = (i == 0) ? '0 : {1'b0, shadow_addr[i-1], 2'b00};
                end
                2'd2: hi = lo + 35'd4;
                2'd3: begin
                    k = 0;
                    while (k < `XLEN && shadow_addr[i][k]) k++;
                    lo = (lo >> (k + 3)) << (k + 3);
                    hi = lo + (35'd1 << (k + 3));
                end
                default: ;
            endcase
            if (a >= lo && a < hi) begin
                case (acc)
                    ACC_READ:  perm = shadow_cfg[i][0];
                    ACC_WRITE: perm = shadow_cfg[i][1];
                    default:   perm = shadow_cfg[i][2];
                endcase
                // Machine mode only checked against locked entries
                return machine ? (perm || !shadow_cfg[i][7]) : perm;
            end
        end
        return machine;
    endfunction

    // One strobed register write that the model drops on a locked entry
    task automatic write_reg(input logic is_cfg, input int idx, input logic [31:0] data);
        @(posedge aclk);
        #1;
        req_valid     = 1'b0;
        csr_wren      = 1'b1;
        csr_wr_is_cfg = is_cfg;
        csr_wr_idx    = idx[1:0];
        csr_wr_data   = data;
        if (!shadow_cfg[idx][7]) begin
            if (is_cfg) shadow_cfg[idx] = data[7:0];
            else        shadow_addr[idx] = data;
        end
        @(posedge aclk);
        #1;
        csr_wren = 1'b0;
    endtask

    // Request held for one cycle and back to back when called in a row
    task automatic issue(input logic [`RLEN-1:0] addr, input pmp_access_e acc,
                         input logic machine, input string name);
        @(posedge aclk);
        #1;
        req_valid   = 1'b1;
        req_addr    = addr;
        req_access  = acc;
        req_machine = machine;
        exp_q.push_back(model_allow(addr, acc, machine));
        name_q.push_back(name);
    endtask

    task automatic idle();
        @(posedge aclk);
        #1;
        req_valid = 1'b0;
    endtask

    // Outputs checked mid-cycle where they are stable
    always @(negedge aclk) begin
        if (!reset && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Response seen with no request outstanding");
                $display("Simulation failed");
                $fatal(1);
            end else begin
                exp_allow = exp_q.pop_front();
                exp_name  = name_q.pop_front();
                check_allow: assert (resp_allow === exp_allow) else begin
                    $display("ERR %s expected %0b actual %0b", exp_name, exp_allow, resp_allow);
                    $display("Simulation failed");
                    $fatal(1);
                end
            end
        end
    end

    // Ten cycles per request plus the reset time
    initial begin
        #(((N_DIRECTED + N_RANDOM) * 10 + RESET_CYCLES) * 8);
        $display("Watchdog expired before all responses arrived");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        aclk          = 1'b0;
        reset         = 1'b1;
        csr_wren      = 1'b0;
        csr_wr_is_cfg = 1'b0;
        csr_wr_idx    = '0;
        csr_wr_data   = '0;
        req_valid     = 1'b0;
        req_addr      = '0;
        req_access    = ACC_READ;
        req_machine   = 1'b0;
        for (int i = 0; i < `PMP_NB_REGION; i++) begin
            shadow_cfg[i]  = 8'h00;
            shadow_addr[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        reset = 1'b0;

        // All regions OFF
        issue(34'h100, ACC_READ, 1'b0, "off_user_read");
        issue(34'h100, ACC_READ, 1'b1, "off_machine_read");
        issue(34'h100, ACC_WRITE, 1'b1, "off_machine_write");
        issue(34'h100, ACC_EXEC, 1'b1, "off_machine_exec");
        idle();

        // NAPOT of several sizes on region 0 with read and write only
        for (int j = 0; j < 3; j++) begin
            size = 1 << (napot_k[j] + 3);
            base = 34'h8000_0000;
            write_reg(1'b0, 0, 32'h2000_0000 | ((32'd1 << napot_k[j]) - 32'd1));
            write_reg(1'b1, 0, 32'h1B);
            issue(base, ACC_READ, 1'b0, "napot_in_read");
            issue(base + 34'(size - 1), ACC_WRITE, 1'b0, "napot_in_write");
            issue(base, ACC_EXEC, 1'b0, "napot_in_exec");
            issue(base - 34'd1, ACC_READ, 1'b0, "napot_below");
            issue(base + 34'(size), ACC_READ, 1'b0, "napot_above");
            repeat (3) begin
                r = $random(seed);
                issue({2'b00, r}, ACC_READ, 1'b0, "napot_random");
            end
            idle();
        end

        // NA4 on region 1 and then TOR on region 2 above it
        write_reg(1'b1, 0, 32'h00);
        write_reg(1'b0, 1, 32'h400);
        write_reg(1'b1, 1, 32'h11);
        issue(34'h1000, ACC_READ, 1'b0, "na4_low");
        issue(34'h1003, ACC_READ, 1'b0, "na4_high");
        issue(34'h1004, ACC_READ, 1'b0, "na4_after");
        issue(34'h0FFC, ACC_READ, 1'b0, "na4_before");
        write_reg(1'b1, 1, 32'h00);
        write_reg(1'b0, 2, 32'h800);
        write_reg(1'b1, 2, 32'h0D);
        issue(34'h1000, ACC_EXEC, 1'b0, "tor_lower_edge");
        issue(34'h1FFF, ACC_EXEC, 1'b0, "tor_upper_edge");
        issue(34'h2000, ACC_EXEC, 1'b0, "tor_past_top");
        issue(34'h0FFF, ACC_EXEC, 1'b0, "tor_below");
        issue(34'h1800, ACC_WRITE, 1'b0, "tor_no_write");
        idle();

        // Region 0 read only inside region 1 read write
        write_reg(1'b0, 0, 32'h1003);
        write_reg(1'b1, 0, 32'h19);
        write_reg(1'b0, 1, 32'h10FF);
        write_reg(1'b1, 1, 32'h1B);
        issue(34'h4000, ACC_WRITE, 1'b0, "prio_low_wins");
        issue(34'h4000, ACC_READ, 1'b0, "prio_low_read");
        issue(34'h4100, ACC_WRITE, 1'b0, "prio_outer_only");
        idle();

        // Locked read only region 3 drops later writes
        write_reg(1'b0, 3, 32'h401F);
        write_reg(1'b1, 3, 32'h99);
        issue(34'h10000, ACC_EXEC, 1'b1, "lock_machine_exec");
        issue(34'h10000, ACC_READ, 1'b1, "lock_machine_read");
        write_reg(1'b1, 3, 32'h1F);
        write_reg(1'b0, 3, 32'h0);
        issue(34'h10000, ACC_EXEC, 1'b1, "lock_write_ignored");
        issue(34'h4000, ACC_WRITE, 1'b1, "unlocked_machine_write");
        idle();

        // Back to back random traffic over all regions
        for (int n = 0; n < N_RANDOM; n++) begin
            r  = $random(seed);
            a2 = $random(seed);
            issue(r[3] ? 34'(a2[16:0]) : {a2[1:0], a2}, pmp_access_e'(2'(r % 32'd3)),
                  r[8], "random_b2b");
        end
        idle();

        // Drain, then leave room for a stray extra response
        while (exp_q.size() != 0) @(posedge aclk);
        repeat (2) @(posedge aclk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* friscv_pmp.f */
+incdir+verilog
verilog/friscv_pmp_pkg.sv
verilog/friscv_pmp_csr.sv
verilog/friscv_pmp_region.sv
verilog/friscv_pmp_match.sv
verilog/friscv_pmp.sv
verification/friscv_pmp_asserts.sv
verification/friscv_pmp_tb.sv

/* Makefile */
# Verilator build and run for the PMP checker testbench

VERILATOR  ?= verilator
TOP        ?= friscv_pmp_tb
FLIST      ?= friscv_pmp.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# Exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
